// File: all.f
rtl/core_pkg.sv
rtl/core_if.sv
rtl/core_ctrl.sv
rtl/core_pc.sv
rtl/core_datapath.sv
rtl/core_debug.sv
rtl/core_module.sv
tests/tb_core_module.sv

// File: Bender.yml
package:
  name: core_tile

sources:
  - files:
      - rtl/core_pkg.sv
      - rtl/core_if.sv
      - rtl/core_ctrl.sv
      - rtl/core_pc.sv
      - rtl/core_datapath.sv
      - rtl/core_debug.sv
      - rtl/core_module.sv
  - target: test
    files:
      - tests/tb_core_module.sv

// File: tests/core_tests.hex
// Word sections: @00 program, @40 data image at byte 0x100, @60 control words,
// @80 trace records (pc insn wben wbreg wbdata), @E0 debug reads (address value)
@00
12000005 14000007 26500000 38880000 10400009 50180100 4A000100 4C000104
1D80FFFF 6180FFFF 22680000 28880000 00000000
@40
5A5A5A5A 00000003
// iwb rty adr, dwb rty adr, iwb err adr, record count, stall after record, store adr, data
@60
0000000C 00000100 00000030 00000010 0000000D 00000100 0000000C
// iwb reqs, dwb reqs, write acks, read acks, debug write adr, data, reads halted, after err
00000012 00000004 00000001 00000002 00000002 00000100 00000009 00000004
// Two trace records per line, wbdata is only compared when wben is set
@80
00000000 12000005 00000001 00000001 00000005 00000004 14000007 00000001 00000002 00000007
00000008 26500000 00000001 00000003 0000000C 0000000C 38880000 00000001 00000004 00000002
00000010 10400009 00000000 00000000 00000000 00000014 50180100 00000000 00000000 00000000
00000018 4A000100 00000001 00000005 0000000C 0000001C 4C000104 00000001 00000006 00000003
00000020 1D80FFFF 00000001 00000006 00000002 00000024 6180FFFF 00000000 00000000 00000000
00000020 1D80FFFF 00000001 00000006 00000001 00000024 6180FFFF 00000000 00000000 00000000
00000020 1D80FFFF 00000001 00000006 00000000 00000024 6180FFFF 00000000 00000000 00000000
00000028 22680000 00000001 00000001 00000011 0000002C 28880000 00000001 00000004 00000111
// Debug reads while stalled, then after the bus error
@E0
00000001 00000011 00000003 0000000C 00000005 0000000C 00000006 00000000
00000000 00000000 00000010 0000002C 00000011 00000001 00000012 0000000F
00000020 00000000
00000011 00000003 00000010 00000030 00000012 00000010 00000004 00000111

// File: tests/tb_core_module.sv
// ----------------------------------------------------------
// Testbench for the processor tile: Wishbone memory models,
// debug port accesses and trace checks from a vector file
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_core_module;
   import core_pkg::*;

   localparam int MEM_WORDS   = 'h60;     // Program and data image
   localparam int TRACE_BASE  = 'h80;     // Five words per record
   localparam int DBG_BASE    = 'hE0;     // Address and value pairs
   localparam int WAIT_LIMIT  = 2000;     // Cycles per wait loop
   localparam int IRTY_ADR    = 'h60;     // Control words
   localparam int DRTY_ADR    = 'h61;
   localparam int IERR_ADR    = 'h62;
   localparam int N_TRACE     = 'h63;
   localparam int STALL_AFTER = 'h64;
   localparam int ST_ADR      = 'h65;
   localparam int ST_DAT      = 'h66;
   localparam int N_IREQS     = 'h67;
   localparam int N_DREQS     = 'h68;
   localparam int N_WR_ACKS   = 'h69;
   localparam int N_RD_ACKS   = 'h6A;
   localparam int DBG_WADR    = 'h6B;
   localparam int DBG_WDAT    = 'h6C;
   localparam int N_DBG_HALT  = 'h6D;
   localparam int N_DBG_ERR   = 'h6E;

   logic                 clk_i = 1'b0;
   logic                 rst_n_i;
   logic                 iwb_cyc_o;
   logic                 iwb_stb_o;
   logic                 iwb_ack_i;
   logic                 iwb_err_i;
   logic                 iwb_rty_i;
   word_t                iwb_adr_o;
   word_t                iwb_dat_i;
   logic [3:0]           iwb_sel_o;
   logic [3:0]           dwb_sel_o;
   logic                 dwb_cyc_o;
   logic                 dwb_stb_o;
   logic                 dwb_we_o;
   logic                 dwb_ack_i;
   logic                 dwb_err_i;
   logic                 dwb_rty_i;
   word_t                dwb_adr_o;
   word_t                dwb_dat_o;
   word_t                dwb_dat_i;
   logic                 dbg_stall_i;
   logic                 dbg_stb_i;
   logic                 dbg_we_i;
   logic                 dbg_ack_o;
   dbg_adr_t             dbg_adr_i;
   word_t                dbg_dat_i;
   word_t                dbg_dat_o;
   logic [TRACE_W-1:0]   trace_o;

   word_t  tv [256];                       // Whole vector file
   word_t  mem [MEM_WORDS];                // Bus memory, both ports
   integer seed         = 32'h6871_f94f;
   int     mismatch_cnt = 0;
   int     fail_cnt     = 0;
   int     rec_cnt      = 0;               // Retired records seen
   int     ireqs        = 0;
   int     dreqs        = 0;
   int     wr_acks      = 0;
   int     rd_acks      = 0;
   int     iwait        = 0;
   int     dwait        = 0;
   logic   ibusy        = 1'b0;            // Transfer started, not yet ended
   logic   dbusy        = 1'b0;
   logic   irty_done    = 1'b0;            // Rty answered only once
   logic   drty_done    = 1'b0;

   core_module i_core_module (.*);

   always #10 clk_i = ~clk_i;

   task automatic check_word(input string name, input word_t got, input word_t exp);
      assert (got === exp) else begin
         $display("MISMATCH %s: got %h, expected %h", name, got, exp);
         mismatch_cnt++;
      end
   endtask

   task automatic wait_records(input int n);
      int cycles;
      cycles = 0;
      while (rec_cnt < n && cycles < WAIT_LIMIT) begin
         @(posedge clk_i);
         cycles++;
      end
      assert (rec_cnt >= n) else begin
         $display("Timeout while waiting for trace record %0d", n);
         fail_cnt++;
      end
   endtask

   // One debug access, returns after the ack edge
   task automatic debug_access(input dbg_adr_t adr, input logic we, input word_t wdat,
                               output word_t rdat);
      int cycles;
      cycles = 0;
      @(posedge clk_i);
      dbg_stb_i <= 1'b1;
      dbg_we_i  <= we;
      dbg_adr_i <= adr;
      dbg_dat_i <= wdat;
      do begin
         @(posedge clk_i);
         cycles++;
      end while (!dbg_ack_o && cycles < WAIT_LIMIT);
      rdat = dbg_dat_o;                    // Valid with the ack
      dbg_stb_i <= 1'b0;
      dbg_we_i  <= 1'b0;
      assert (dbg_ack_o) else begin
         $display("Timeout while waiting for the debug ack at address %h", adr);
         fail_cnt++;
      end
   endtask

   task automatic debug_reads(input int first, input int count);
      word_t    rdat;
      dbg_adr_t adr;
      for (int k = 0; k < count; k++) begin
         adr = tv[first + 2 * k][15:0];
         debug_access(adr, 1'b0, '0, rdat);
         check_word($sformatf("dbg_dat_o @%h", adr), rdat, tv[first + 2 * k + 1]);
      end
   endtask

   // Instruction port memory
   always @(posedge clk_i) begin : imem_model
      int idx;
      iwb_ack_i <= 1'b0;
      iwb_err_i <= 1'b0;
      iwb_rty_i <= 1'b0;
      if (iwb_cyc_o && iwb_stb_o && !(iwb_ack_i || iwb_err_i || iwb_rty_i)) begin
         if (!ibusy) begin
            ibusy = 1'b1;
            ireqs++;
            iwait = $random(seed) & 3;     // 0..3 wait states
            check_word("iwb_sel_o", iwb_sel_o, 4'hF);
         end
         if (iwait > 0) begin
            iwait--;
         end else begin
            ibusy = 1'b0;
            idx   = iwb_adr_o[31:2];
            assert (idx < MEM_WORDS) else begin
               $display("Instruction fetch outside the memory image at %h", iwb_adr_o);
               fail_cnt++;
            end
            if (iwb_adr_o == tv[IERR_ADR]) begin
               iwb_err_i <= 1'b1;
            end else if (iwb_adr_o == tv[IRTY_ADR] && !irty_done) begin
               irty_done = 1'b1;
               iwb_rty_i <= 1'b1;
            end else begin
               iwb_ack_i <= 1'b1;
               iwb_dat_i <= mem[idx];
            end
         end
      end
   end

   // Data port memory, stores are checked against the expected word
   always @(posedge clk_i) begin : dmem_model
      int idx;
      dwb_ack_i <= 1'b0;
      dwb_err_i <= 1'b0;
      dwb_rty_i <= 1'b0;
      if (dwb_cyc_o && dwb_stb_o && !(dwb_ack_i || dwb_err_i || dwb_rty_i)) begin
         if (!dbusy) begin
            dbusy = 1'b1;
            dreqs++;
            dwait = $random(seed) & 3;
            check_word("dwb_sel_o", dwb_sel_o, 4'hF);
         end
         if (dwait > 0) begin
            dwait--;
         end else begin
            dbusy = 1'b0;
            idx   = dwb_adr_o[31:2];
            assert (idx < MEM_WORDS) else begin
               $display("Data access outside the memory image at %h", dwb_adr_o);
               fail_cnt++;
            end
            if (dwb_adr_o == tv[DRTY_ADR] && !drty_done) begin
               drty_done = 1'b1;
               dwb_rty_i <= 1'b1;
            end else if (dwb_we_o) begin
               check_word("dwb_adr_o", dwb_adr_o, tv[ST_ADR]);
               check_word("dwb_dat_o", dwb_dat_o, tv[ST_DAT]);
               mem[idx] = dwb_dat_o;
               wr_acks++;
               dwb_ack_i <= 1'b1;
            end else begin
               dwb_dat_i <= mem[idx];
               rd_acks++;
               dwb_ack_i <= 1'b1;
            end
         end
      end
   end

   always @(posedge clk_i) begin : trace_checker
      int    base;
      string tag;
      if (trace_o[TRACE_VALID_BIT]) begin
         base = TRACE_BASE + 5 * rec_cnt;
         tag  = $sformatf("trace_o record %0d", rec_cnt);
         assert (rec_cnt < tv[N_TRACE]) else begin
            $display("Unexpected extra trace record at pc %h", trace_o[TRACE_PC_LSB +: 32]);
            fail_cnt++;
         end
         if (rec_cnt < tv[N_TRACE]) begin
            check_word({tag, " pc"}, trace_o[TRACE_PC_LSB +: 32], tv[base]);
            check_word({tag, " insn"}, trace_o[TRACE_INSN_LSB +: 32], tv[base + 1]);
            check_word({tag, " wben"}, trace_o[TRACE_WBEN_BIT], tv[base + 2]);
            check_word({tag, " wbreg"}, trace_o[TRACE_WBREG_LSB +: TRACE_WBREG_W],
                       tv[base + 3]);
            if (tv[base + 2][0]) begin
               check_word({tag, " wbdata"}, trace_o[TRACE_WBDATA_LSB +: 32], tv[base + 4]);
            end
         end
         rec_cnt <= rec_cnt + 1;           // Seen by waiters one edge later
      end
   end

   initial begin
      word_t rdat;
      int    cycles;
      for (int i = 0; i < 256; i++) begin
         tv[i] = 32'hA5A5_0000 ^ i;        // Unloaded words show their index
      end
      $readmemh("tests/core_tests.hex", tv);
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = tv[i];
      end
      rst_n_i     <= 1'b0;
      iwb_ack_i   <= 1'b0;
      iwb_err_i   <= 1'b0;
      iwb_rty_i   <= 1'b0;
      iwb_dat_i   <= '0;
      dwb_ack_i   <= 1'b0;
      dwb_err_i   <= 1'b0;
      dwb_rty_i   <= 1'b0;
      dwb_dat_i   <= '0;
      dbg_stall_i <= 1'b0;
      dbg_stb_i   <= 1'b0;
      dbg_we_i    <= 1'b0;
      dbg_adr_i   <= '0;
      dbg_dat_i   <= '0;
      repeat (16) @(posedge clk_i);
      assert (!iwb_cyc_o && !iwb_stb_o && !dwb_cyc_o && !dwb_stb_o) else begin
         $display("A bus request is active during reset");
         fail_cnt++;
      end
      assert (!dbg_ack_o && !trace_o[TRACE_VALID_BIT]) else begin
         $display("Debug ack or trace valid is active during reset");
         fail_cnt++;
      end
      rst_n_i <= 1'b1;

      cycles = 0;
      do begin
         @(posedge clk_i);
         cycles++;
      end while (!iwb_stb_o && cycles < WAIT_LIMIT);
      assert (iwb_stb_o) else begin
         $display("No instruction fetch after reset release");
         fail_cnt++;
      end
      check_word("iwb_adr_o", iwb_adr_o, RESET_PC);

      // Stall after the loop exit, core halts behind the next insn
      wait_records(tv[STALL_AFTER] + 1);
      dbg_stall_i <= 1'b1;
      debug_reads(DBG_BASE, tv[N_DBG_HALT]);
      check_word("trace records while halted", rec_cnt, tv[STALL_AFTER] + 2);
      debug_access(tv[DBG_WADR][15:0], 1'b1, tv[DBG_WDAT], rdat);
      @(posedge clk_i);
      dbg_stall_i <= 1'b0;

      // Runs into the err fetch and stays halted
      wait_records(tv[N_TRACE]);
      debug_reads(DBG_BASE + 2 * tv[N_DBG_HALT], tv[N_DBG_ERR]);
      @(posedge clk_i);
      dbg_stall_i <= 1'b1;
      repeat (4) @(posedge clk_i);
      dbg_stall_i <= 1'b0;
      for (int i = 0; i < 40; i++) begin
         @(posedge clk_i);
         assert (!iwb_stb_o) else begin
            $display("Instruction fetch issued after a bus error");
            fail_cnt++;
         end
      end

      check_word("trace record count", rec_cnt, tv[N_TRACE]);
      check_word("iwb request count", ireqs, tv[N_IREQS]);
      check_word("dwb request count", dreqs, tv[N_DREQS]);
      check_word("dwb write acks", wr_acks, tv[N_WR_ACKS]);
      check_word("dwb read acks", rd_acks, tv[N_RD_ACKS]);
      $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
      if (mismatch_cnt == 0 && fail_cnt == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: rtl/core_module.sv
// ----------------------------------------------------------
// Processor tile top level with Wishbone instruction and data
// ports, debug register port and flat execution trace
// ----------------------------------------------------------
`timescale 1ns/1ps

module core_module (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   output logic                          iwb_cyc_o,
   output logic                          iwb_stb_o,
   output core_pkg::word_t               iwb_adr_o,
   output logic [3:0]                    iwb_sel_o,
   input  logic                          iwb_ack_i,
   input  logic                          iwb_err_i,
   input  logic                          iwb_rty_i,
   input  core_pkg::word_t               iwb_dat_i,
   output logic                          dwb_cyc_o,
   output logic                          dwb_stb_o,
   output core_pkg::word_t               dwb_adr_o,
   output logic [3:0]                    dwb_sel_o,
   output logic                          dwb_we_o,
   output core_pkg::word_t               dwb_dat_o,
   input  logic                          dwb_ack_i,
   input  logic                          dwb_err_i,
   input  logic                          dwb_rty_i,
   input  core_pkg::word_t               dwb_dat_i,
   input  logic                          dbg_stall_i,
   input  logic                          dbg_stb_i,
   input  logic                          dbg_we_i,
   input  core_pkg::dbg_adr_t            dbg_adr_i,
   input  core_pkg::word_t               dbg_dat_i,
   output core_pkg::word_t               dbg_dat_o,
   output logic                          dbg_ack_o,
   output logic [core_pkg::TRACE_W-1:0]  trace_o
);
   import core_pkg::*;

   insn_t       insn;
   word_t       load_data;
   ctrl_state_e state;
   logic        bus_err;
   word_t       pc;
   word_t       retired;
   logic        branch_taken;
   word_t       branch_target;
   logic        dbg_pc_we;

   trace_if trace_bus ();
   dbg_if   dbg_bus ();

   core_ctrl i_core_ctrl (
      .clk_i, .rst_n_i,
      .iwb_ack_i, .iwb_err_i, .iwb_rty_i, .iwb_dat_i,
      .dwb_ack_i, .dwb_err_i, .dwb_rty_i, .dwb_dat_i,
      .dbg_stall_i,
      .iwb_cyc_o, .iwb_stb_o, .dwb_cyc_o, .dwb_stb_o, .dwb_we_o,
      .insn_o      (insn),
      .load_data_o (load_data),
      .state_o     (state),
      .bus_err_o   (bus_err)
   );

   core_pc i_core_pc (
      .clk_i, .rst_n_i,
      .state_i         (state),
      .branch_taken_i  (branch_taken),
      .branch_target_i (branch_target),
      .dbg_pc_we_i     (dbg_pc_we),
      .dbg_wdat_i      (dbg_bus.wdat),
      .pc_o            (pc),
      .retired_o       (retired)
   );

   core_datapath i_core_datapath (
      .clk_i, .rst_n_i,
      .state_i         (state),
      .insn_i          (insn),
      .load_data_i     (load_data),
      .pc_i            (pc),
      .dwb_adr_o, .dwb_dat_o,
      .branch_taken_o  (branch_taken),
      .branch_target_o (branch_target),
      .trace           (trace_bus),
      .dbg             (dbg_bus)
   );

   core_debug i_core_debug (
      .clk_i, .rst_n_i,
      .dbg_stb_i, .dbg_we_i, .dbg_adr_i, .dbg_dat_i,
      .state_i     (state),
      .bus_err_i   (bus_err),
      .pc_i        (pc),
      .retired_i   (retired),
      .dbg_dat_o, .dbg_ack_o,
      .dbg_pc_we_o (dbg_pc_we),
      .bus         (dbg_bus)
   );

   assign iwb_adr_o = pc;       // Fetch from current PC
   assign iwb_sel_o = 4'hF;     // Single-beat full words
   assign dwb_sel_o = 4'hF;

   assign trace_o[TRACE_VALID_BIT]                  = trace_bus.valid;
   assign trace_o[TRACE_PC_LSB +: 32]               = trace_bus.pc;
   assign trace_o[TRACE_INSN_LSB +: 32]             = trace_bus.insn;
   assign trace_o[TRACE_WBEN_BIT]                   = trace_bus.wben;
   assign trace_o[TRACE_WBREG_LSB +: TRACE_WBREG_W] = trace_bus.wbreg;
   assign trace_o[TRACE_WBDATA_LSB +: 32]           = trace_bus.wbdata;

endmodule

// File: rtl/core_debug.sv
// ----------------------------------------------------------
// Debug unit access decoder; acks only while the core is
// halted and returns GPR, PC, status or retire count
// ----------------------------------------------------------
`timescale 1ns/1ps

module core_debug (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  dbg_stb_i,
   input  logic                  dbg_we_i,
   input  core_pkg::dbg_adr_t    dbg_adr_i,
   input  core_pkg::word_t       dbg_dat_i,
   input  core_pkg::ctrl_state_e state_i,
   input  logic                  bus_err_i,
   input  core_pkg::word_t       pc_i,
   input  core_pkg::word_t       retired_i,
   output core_pkg::word_t       dbg_dat_o,
   output logic                  dbg_ack_o,
   output logic                  dbg_pc_we_o,
   dbg_if.mst                    bus
);
   import core_pkg::*;

   logic  halted;
   logic  ack;
   logic  ack_q;      // Blocks a second ack while strobe is still up
   logic  gpr_hit;
   word_t rdata;

   assign halted  = (state_i == HALTED);
   assign ack     = dbg_stb_i && halted && !ack_q;  // Held strobe waits here
   assign gpr_hit = (dbg_adr_i[15:3] == DBG_GPR_BASE[15:3]);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= ack;
      end
   end

   always_comb begin
      if (gpr_hit) begin
         rdata = bus.rdat;                           // From register file
      end else begin
         case (dbg_adr_i)
            DBG_PC:      rdata = pc_i;
            DBG_STATUS:  rdata = {30'd0, bus_err_i, halted};
            DBG_RETIRED: rdata = retired_i;
            default:     rdata = '0;                 // Unmapped
         endcase
      end
   end

   // Qualified access toward datapath, valid in the ack cycle
   assign bus.stb  = ack;
   assign bus.we   = dbg_we_i;
   assign bus.adr  = dbg_adr_i;
   assign bus.wdat = dbg_dat_i;

   assign dbg_dat_o   = rdata;
   assign dbg_ack_o   = ack;
   assign dbg_pc_we_o = ack && dbg_we_i && (dbg_adr_i == DBG_PC);

   // Host keeps the strobe up until the ack
   a_stb_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (dbg_stb_i && !dbg_ack_o) |=> dbg_stb_i);

endmodule

// File: rtl/core_datapath.sv
// ----------------------------------------------------------
// Register file, decode, ALU and address generation; writes
// back in RETIRE and drives the execution trace record
// ----------------------------------------------------------
`timescale 1ns/1ps

module core_datapath (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  core_pkg::ctrl_state_e state_i,
   input  core_pkg::insn_t       insn_i,
   input  core_pkg::word_t       load_data_i,
   input  core_pkg::word_t       pc_i,
   output core_pkg::word_t       dwb_adr_o,
   output core_pkg::word_t       dwb_dat_o,
   output logic                  branch_taken_o,
   output core_pkg::word_t       branch_target_o,
   trace_if.src                  trace,
   dbg_if.slv                    dbg
);
   import core_pkg::*;

   word_t    rf_q [8];      // r0 storage never read
   opc_t     opc;
   reg_idx_t rd;
   reg_idx_t rs;
   reg_idx_t rt;
   word_t    imm;
   word_t    rs_val;
   word_t    rt_val;
   word_t    wb_data;
   logic     wb_en;
   logic     gpr_hit;

   function automatic word_t rf_read(reg_idx_t idx);
      return (idx == '0) ? '0 : rf_q[idx];
   endfunction

   assign opc    = insn_i[OPC_LSB +: 4];
   assign rd     = insn_i[RD_LSB +: 3];
   assign rs     = insn_i[RS_LSB +: 3];
   assign rt     = insn_i[RT_LSB +: 3];
   assign imm    = {{(32-IMM_W){insn_i[IMM_W-1]}}, insn_i[IMM_W-1:0]};
   assign rs_val = rf_read(rs);
   assign rt_val = rf_read(rt);

   always_comb begin
      wb_data = '0;
      wb_en   = 1'b0;
      case (opc)
         OPC_ADDI: begin
            wb_data = rs_val + imm;
            wb_en   = 1'b1;
         end
         OPC_ADD: begin
            wb_data = rs_val + rt_val;
            wb_en   = 1'b1;
         end
         OPC_SUB: begin
            wb_data = rs_val - rt_val;
            wb_en   = 1'b1;
         end
         OPC_LW: begin
            wb_data = load_data_i;                   // Latched in MEM
            wb_en   = 1'b1;
         end
         default: wb_en = 1'b0;                      // NOP, SW, BNE
      endcase
      wb_en = wb_en && (rd != '0);
   end

   assign dwb_adr_o       = rs_val + imm;           // Effective address
   assign dwb_dat_o       = rt_val;
   assign branch_taken_o  = (opc == OPC_BNE) && (rs_val != rt_val);
   assign branch_target_o = pc_i + (imm << 2);

   // Debug GPR window r0..r7
   assign gpr_hit  = (dbg.adr[15:3] == DBG_GPR_BASE[15:3]);
   assign dbg.rdat = gpr_hit ? rf_read(dbg.adr[2:0]) : '0;

   always_ff @(posedge clk_i) begin
      if (state_i == RETIRE && wb_en) begin
         rf_q[rd] <= wb_data;
      end else if (dbg.stb && dbg.we && gpr_hit) begin
         rf_q[dbg.adr[2:0]] <= dbg.wdat;            // Only strobed while halted
      end
   end

   assign trace.valid  = (state_i == RETIRE);
   assign trace.pc     = pc_i;
   assign trace.insn   = insn_i;
   assign trace.wben   = wb_en;
   assign trace.wbreg  = {2'b00, rd};
   assign trace.wbdata = wb_data;

   // Debug decoder must never write the GPRs under a running core
   a_dbg_wr_halted: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (dbg.stb && dbg.we) |-> (state_i == HALTED));

endmodule

// File: rtl/core_pc.sv
// ----------------------------------------------------------
// Program counter and retired-instruction counter, updated
// in RETIRE or by a debug write while halted
// ----------------------------------------------------------
`timescale 1ns/1ps

module core_pc (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  core_pkg::ctrl_state_e state_i,
   input  logic                  branch_taken_i,
   input  core_pkg::word_t       branch_target_i,
   input  logic                  dbg_pc_we_i,
   input  core_pkg::word_t       dbg_wdat_i,
   output core_pkg::word_t       pc_o,
   output core_pkg::word_t       retired_o
);
   import core_pkg::*;

   word_t pc_q;
   word_t retired_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pc_q      <= RESET_PC;
         retired_q <= '0;
      end else if (state_i == RETIRE) begin
         pc_q      <= branch_taken_i ? branch_target_i : pc_q + 32'd4;
         retired_q <= retired_q + 32'd1;
      end else if (dbg_pc_we_i && state_i == HALTED) begin
         pc_q      <= {dbg_wdat_i[31:2], 2'b00};     // Low bits dropped
      end
   end

   assign pc_o      = pc_q;
   assign retired_o = retired_q;

   // Debug PC writes only arrive with the core halted
   a_dbg_pc_halted: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      dbg_pc_we_i |-> (state_i == HALTED));

endmodule

// File: rtl/core_ctrl.sv
// ----------------------------------------------------------
// Sequencer: fetch, execute, memory, retire and halt FSM,
// drives both Wishbone ports and latches insn and load data
// ----------------------------------------------------------
`timescale 1ns/1ps

module core_ctrl (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  iwb_ack_i,
   input  logic                  iwb_err_i,
   input  logic                  iwb_rty_i,
   input  core_pkg::word_t       iwb_dat_i,
   input  logic                  dwb_ack_i,
   input  logic                  dwb_err_i,
   input  logic                  dwb_rty_i,
   input  core_pkg::word_t       dwb_dat_i,
   input  logic                  dbg_stall_i,
   output logic                  iwb_cyc_o,
   output logic                  iwb_stb_o,
   output logic                  dwb_cyc_o,
   output logic                  dwb_stb_o,
   output logic                  dwb_we_o,
   output core_pkg::insn_t       insn_o,
   output core_pkg::word_t       load_data_o,
   output core_pkg::ctrl_state_e state_o,
   output logic                  bus_err_o
);
   import core_pkg::*;

   ctrl_state_e state_q;
   ctrl_state_e state_d;
   logic        iwb_req_q;    // Registered request, low through reset
   logic        dwb_req_q;
   logic        bus_err_q;    // Sticky until reset
   insn_t       insn_q;
   word_t       load_q;
   opc_t        opc;
   logic        is_mem;
   logic        iwb_ack;
   logic        iwb_err;
   logic        dwb_ack;
   logic        dwb_err;

   assign opc    = insn_q[OPC_LSB +: 4];
   assign is_mem = (opc == OPC_LW) || (opc == OPC_SW);

   // Terminations only count while our strobe is up
   assign iwb_ack = iwb_req_q && iwb_ack_i;
   assign iwb_err = iwb_req_q && iwb_err_i;
   assign dwb_ack = dwb_req_q && dwb_ack_i;
   assign dwb_err = dwb_req_q && dwb_err_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         FETCH: begin
            if (iwb_err) begin
               state_d = HALTED;
            end else if (iwb_ack) begin
               state_d = EXEC;
            end                                      // Rty keeps the request up
         end
         EXEC:    state_d = is_mem ? MEM : RETIRE;
         MEM: begin
            if (dwb_err) begin
               state_d = HALTED;
            end else if (dwb_ack) begin
               state_d = RETIRE;
            end
         end
         RETIRE:  state_d = dbg_stall_i ? HALTED : FETCH;  // Insn boundary
         HALTED:  state_d = (!dbg_stall_i && !bus_err_q) ? FETCH : HALTED;
         default: state_d = HALTED;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q   <= FETCH;
         iwb_req_q <= 1'b0;
         dwb_req_q <= 1'b0;
         bus_err_q <= 1'b0;
      end else begin
         state_q   <= state_d;
         iwb_req_q <= (state_d == FETCH);            // Same transfer again after rty
         dwb_req_q <= (state_d == MEM);
         bus_err_q <= bus_err_q || iwb_err || dwb_err;
      end
   end

   always_ff @(posedge clk_i) begin
      if (iwb_ack && state_q == FETCH) begin
         insn_q <= iwb_dat_i;                        // Held until next fetch ack
      end
      if (dwb_ack && state_q == MEM) begin
         load_q <= dwb_dat_i;
      end
   end

   assign iwb_cyc_o   = iwb_req_q;
   assign iwb_stb_o   = iwb_req_q;
   assign dwb_cyc_o   = dwb_req_q;
   assign dwb_stb_o   = dwb_req_q;
   assign dwb_we_o    = dwb_req_q && (opc == OPC_SW);
   assign insn_o      = insn_q;
   assign load_data_o = load_q;
   assign state_o     = state_q;
   assign bus_err_o   = bus_err_q;

   // Request stays up until ack, err or rty
   a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ((iwb_stb_o && !(iwb_ack_i || iwb_err_i || iwb_rty_i)) |=> iwb_stb_o) and
      ((dwb_stb_o && !(dwb_ack_i || dwb_err_i || dwb_rty_i)) |=> dwb_stb_o));

   // Slaves terminate only a pending request
   a_no_stray_term: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (!iwb_req_q |-> !(iwb_ack_i || iwb_err_i || iwb_rty_i)) and
      (!dwb_req_q |-> !(dwb_ack_i || dwb_err_i || dwb_rty_i)));

endmodule

// File: rtl/core_if.sv
// ----------------------------------------------------------
// Internal bundles: trace record from the datapath and the
// qualified debug access from the debug decoder
// ----------------------------------------------------------
`timescale 1ns/1ps

interface trace_if;
   import core_pkg::*;

   logic                     valid;   // One cycle per retired insn
   word_t                    pc;
   insn_t                    insn;
   logic                     wben;    // GPR write, never for r0
   logic [TRACE_WBREG_W-1:0] wbreg;
   word_t                    wbdata;

   modport src (output valid, pc, insn, wben, wbreg, wbdata);
   modport snk (input  valid, pc, insn, wben, wbreg, wbdata);
endinterface

interface dbg_if;
   import core_pkg::*;

   logic     stb;     // High in the ack cycle only
   logic     we;
   dbg_adr_t adr;
   word_t    wdat;
   word_t    rdat;    // GPR read data back from the datapath

   modport mst (output stb, we, adr, wdat, input rdat);
   modport slv (input  stb, we, adr, wdat, output rdat);
endinterface

// File: rtl/core_pkg.sv
// ----------------------------------------------------------
// Shared widths, opcodes, FSM states, trace field positions
// and debug address map for the processor tile
// ----------------------------------------------------------
package core_pkg;

   typedef logic [31:0] word_t;        // Data and address word
   typedef logic [31:0] insn_t;        // Raw instruction
   typedef logic [2:0]  reg_idx_t;     // GPR index, r0 reads zero
   typedef logic [15:0] dbg_adr_t;     // Debug unit address
   typedef logic [3:0]  opc_t;         // Major opcode

   // Opcodes in insn[31:28]
   localparam opc_t OPC_NOP  = 4'd0;
   localparam opc_t OPC_ADDI = 4'd1;
   localparam opc_t OPC_ADD  = 4'd2;
   localparam opc_t OPC_SUB  = 4'd3;
   localparam opc_t OPC_LW   = 4'd4;
   localparam opc_t OPC_SW   = 4'd5;
   localparam opc_t OPC_BNE  = 4'd6;

   localparam int OPC_LSB = 28;        // Field positions
   localparam int RD_LSB  = 25;
   localparam int RS_LSB  = 22;
   localparam int RT_LSB  = 19;
   localparam int IMM_W   = 16;        // Sign-extended immediate

   localparam word_t RESET_PC = 32'h0000_0000;

   typedef enum logic [2:0] {FETCH, EXEC, MEM, RETIRE, HALTED} ctrl_state_e;

   // Trace vector, valid on top, wbdata at bit 0
   localparam int TRACE_WBREG_W    = 5;
   localparam int TRACE_WBDATA_LSB = 0;
   localparam int TRACE_WBREG_LSB  = TRACE_WBDATA_LSB + 32;
   localparam int TRACE_WBEN_BIT   = TRACE_WBREG_LSB + TRACE_WBREG_W;
   localparam int TRACE_INSN_LSB   = TRACE_WBEN_BIT + 1;
   localparam int TRACE_PC_LSB     = TRACE_INSN_LSB + 32;
   localparam int TRACE_VALID_BIT  = TRACE_PC_LSB + 32;
   localparam int TRACE_W          = TRACE_VALID_BIT + 1;     // 103 bits

   localparam dbg_adr_t DBG_GPR_BASE = 16'h0000;  // r0..r7
   localparam dbg_adr_t DBG_PC       = 16'h0010;
   localparam dbg_adr_t DBG_STATUS   = 16'h0011;  // [0] halted, [1] bus error
   localparam dbg_adr_t DBG_RETIRED  = 16'h0012;

endpackage
